// File: list.f
+incdir+source
source/mf2_pkg.sv
source/mf2_control.sv
source/mf2_capture.sv
source/mf2_ram.sv
source/mf2_unit.sv
verif/tb_clock.sv
verif/tb_mf2_unit.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the Multiface Two testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
	--top-module tb_mf2_unit \
	-f list.f \
	-o tb_mf2_unit_sim

./obj_dir/tb_mf2_unit_sim > sim.log
cat sim.log

if grep -q "sim failed" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi

echo "Simulation finished without failure"

// File: source/mf2_capture.sv
`timescale 1ns/100ps
`default_nettype none

`include "mf2_consts.svh"

module mf2_capture
	import mf2_pkg::*;
(
	input  wire       clk_sys,
	input  wire       reset,
	input  cpu_addr_t cpu_addr,
	input  cpu_data_t cpu_dout,
	input  wire       io_wr,
	input  wire       mem_wr,
	input  wire       ram_en,
	output mf2_addr_t ram_addr,
	output cpu_data_t ram_wdata,
	output logic      ram_we
);

	logic      io_wr_q;
	logic      io_wr_rise;
	logic [4:0] pen_index;   // Bit 4 means border
	logic [3:0] crtc_reg;

	mf2_addr_t cell_addr;
	logic      cell_hit;
	logic      pen_sel;
	logic      crtc_sel;
	logic      shadow_wr;
	logic      cpu_wr;

	assign io_wr_rise = io_wr & ~io_wr_q;

	//////////////////////////////
	// Shadow cell decode
	//////////////////////////////

	always_comb begin
		cell_addr = '0;
		cell_hit  = 1'b1;
		case (cpu_addr[15:8])
			`GA_PORT: begin
				// Gate array function in data bits 7:6
				case (cpu_dout[7:6])
					2'b00: cell_addr = `CELL_PEN_INDEX;
					2'b01: cell_addr = pen_index[4] ? `CELL_BORDER
						: `CELL_PEN_BASE + mf2_addr_t'(pen_index[3:0]);
					2'b10: cell_addr = `CELL_MODE;
					default: cell_addr = `CELL_BANKING;
				endcase
			end
			`CRTC_SEL_PORT: cell_addr = `CELL_CRTC_SEL;
			`CRTC_VAL_PORT: cell_addr = `CELL_CRTC_BASE + mf2_addr_t'(crtc_reg);
			`PPI_CTRL_PORT: cell_addr = `CELL_PPI;   // 8255 control
			`ROM_SEL_PORT:  cell_addr = `CELL_ROM_SEL;
			default:        cell_hit  = 1'b0;
		endcase
	end

	assign pen_sel  = (cpu_addr[15:8] == `GA_PORT) && (cpu_dout[7:6] == 2'b00);
	assign crtc_sel = (cpu_addr[15:8] == `CRTC_SEL_PORT);

	// Shadow copy wins over a normal RAM write
	assign shadow_wr = io_wr_rise & cell_hit;
	assign cpu_wr    = mem_wr & ram_en;

	//////////////////////////////
	// Request register
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_q   <= 1'b0;
			pen_index <= '0;
			crtc_reg  <= '0;
			ram_we    <= 1'b0;
		end else begin
			io_wr_q <= io_wr;
			ram_we  <= shadow_wr | cpu_wr;
			if (shadow_wr && pen_sel)
				pen_index <= cpu_dout[4:0];
			if (shadow_wr && crtc_sel)
				crtc_reg <= cpu_dout[3:0];
		end
	end

	always_ff @(posedge clk_sys) begin
		ram_addr  <= shadow_wr ? cell_addr : cpu_addr[12:0];   // Read address otherwise
		ram_wdata <= cpu_dout;
	end

endmodule

`default_nettype wire

// File: source/mf2_consts.svh
`ifndef MF2_CONSTS_SVH
`define MF2_CONSTS_SVH

////////////////////////////////
// CPU vectors and paging
////////////////////////////////

`define MF2_NMI_VECTOR   16'h0066   // Fetch here enables the unit
`define MF2_HIDE_VECTOR  16'h0065   // Fetch here hides it
`define MF2_PAGE_PORT    16'hFEE8   // Bit 1 set gives page-out port FEEA

// Top three address bits
`define MF2_ROM_WINDOW   3'b000
`define MF2_RAM_WINDOW   3'b001

// Data seen by the CPU when the unit is not read
`define MF2_READ_IDLE    8'hFF

////////////////////////////////
// Shadowed I/O ports
////////////////////////////////

`define GA_PORT          8'h7F
`define CRTC_SEL_PORT    8'hBC
`define CRTC_VAL_PORT    8'hBD
`define PPI_CTRL_PORT    8'hF7
`define ROM_SEL_PORT     8'hDF

// Fixed cells in the 8 KB RAM
`define CELL_PEN_INDEX   13'h1FCF
`define CELL_BORDER      13'h1FDF
`define CELL_PEN_BASE    13'h1F90   // Plus pen number
`define CELL_MODE        13'h1FEF
`define CELL_BANKING     13'h1FFF
`define CELL_CRTC_SEL    13'h1CFF
`define CELL_CRTC_BASE   13'h1DB0   // Plus CRTC register number
`define CELL_PPI         13'h17FF
`define CELL_ROM_SEL     13'h1AAC

`endif

// File: source/mf2_control.sv
`timescale 1ns/100ps
`default_nettype none

`include "mf2_consts.svh"

module mf2_control
	import mf2_pkg::*;
(
	input  wire       clk_sys,
	input  wire       reset,
	input  mf2_mode_t mode,
	input  cpu_addr_t cpu_addr,
	input  wire       m1,
	input  wire       io_wr,
	input  wire       key_nmi,
	output logic      nmi,
	output logic      mf2_en,
	output logic      rom_en,
	output logic      ram_en
);

	logic m1_q;
	logic io_wr_q;
	logic key_nmi_q;
	logic hidden;   // Paging port has no effect while set

	logic m1_rise;
	logic io_wr_rise;
	logic key_rise;
	logic page_hit;

	assign m1_rise    = m1 & ~m1_q;
	assign io_wr_rise = io_wr & ~io_wr_q;
	assign key_rise   = key_nmi & ~key_nmi_q;

	// FEE8 to FEEB, bit 1 picks in or out
	assign page_hit = ({cpu_addr[15:2], 2'b00} == `MF2_PAGE_PORT);

	//////////////////////////////
	// Freeze and paging state
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			m1_q      <= 1'b0;
			io_wr_q   <= 1'b0;
			key_nmi_q <= 1'b0;
			nmi       <= 1'b0;
			mf2_en    <= 1'b0;
			hidden    <= (mode != mf2_mode_enabled);
		end else begin
			m1_q      <= m1;
			io_wr_q   <= io_wr;
			key_nmi_q <= key_nmi;

			if (key_rise && !mf2_en && mode != mf2_mode_disabled)
				nmi <= 1'b1;   // Button pressed

			// CPU takes the NMI
			if (m1_rise && nmi && cpu_addr == `MF2_NMI_VECTOR) begin
				mf2_en <= 1'b1;
				hidden <= 1'b0;
				nmi    <= 1'b0;
			end

			if (m1_rise && mf2_en && cpu_addr == `MF2_HIDE_VECTOR)
				hidden <= 1'b1;

			if (io_wr_rise && page_hit)
				mf2_en <= ~cpu_addr[1] & ~hidden;   // Hidden unit can only page out
		end
	end

	// Lowest 16 KB split into ROM and RAM halves
	assign rom_en = mf2_en && (cpu_addr[15:13] == `MF2_ROM_WINDOW);
	assign ram_en = mf2_en && (cpu_addr[15:13] == `MF2_RAM_WINDOW);

endmodule

`default_nettype wire

// File: source/mf2_pkg.sv
`default_nettype none

package mf2_pkg;

	// Z80 side of the bus
	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0]  cpu_data_t;

	// Offset into the 8 KB shadow RAM
	typedef logic [12:0] mf2_addr_t;

	// Option setting for the unit
	typedef enum logic [1:0] {
		mf2_mode_enabled  = 2'b00,
		mf2_mode_hidden   = 2'b01,   // Present but starts invisible
		mf2_mode_disabled = 2'b10    // Freeze button ignored
	} mf2_mode_t;

endpackage

`default_nettype wire

// File: source/mf2_ram.sv
`timescale 1ns/100ps
`default_nettype none

`include "mf2_consts.svh"

module mf2_ram
	import mf2_pkg::*;
(
	input  wire       clk_sys,
	input  mf2_addr_t ram_addr,
	input  cpu_data_t ram_wdata,
	input  wire       ram_we,
	input  wire       mem_rd,
	input  wire       ram_en,
	output cpu_data_t mf2_dout
);

	cpu_data_t mem [8192];
	cpu_data_t rd_data;

	logic rd_qual_a;   // Lines up with ram_addr
	logic rd_qual_d;   // Lines up with rd_data

	// Write-first port
	always_ff @(posedge clk_sys) begin
		if (ram_we) begin
			mem[ram_addr] <= ram_wdata;
			rd_data       <= ram_wdata;
		end else begin
			rd_data <= mem[ram_addr];
		end
	end

	// Read strobe follows the address pipeline
	always_ff @(posedge clk_sys) begin
		rd_qual_a <= mem_rd & ram_en;
		rd_qual_d <= rd_qual_a;
	end

	assign mf2_dout = rd_qual_d ? rd_data : `MF2_READ_IDLE;   // Bus is wired-AND

endmodule

`default_nettype wire

// File: source/mf2_unit.sv
`timescale 1ns/100ps
`default_nettype none

module mf2_unit
	import mf2_pkg::*;
(
	input  wire       clk_sys,
	input  wire       reset,
	input  mf2_mode_t mode,
	input  cpu_addr_t cpu_addr,
	input  cpu_data_t cpu_dout,
	input  wire       m1,
	input  wire       io_wr,
	input  wire       mem_rd,
	input  wire       mem_wr,
	input  wire       key_nmi,
	output wire       nmi,
	output wire       mf2_en,
	output wire       rom_en,
	output wire       ram_en,
	output cpu_data_t mf2_dout
);

	// Capture to RAM request
	mf2_addr_t ram_addr;
	cpu_data_t ram_wdata;
	wire       ram_we;

	//////////////////////////////
	// Freeze, paging, windows
	//////////////////////////////

	mf2_control mf2_control_i (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.mode     (mode),
		.cpu_addr (cpu_addr),
		.m1       (m1),
		.io_wr    (io_wr),
		.key_nmi  (key_nmi),
		.nmi      (nmi),
		.mf2_en   (mf2_en),
		.rom_en   (rom_en),
		.ram_en   (ram_en)
	);

	// Stage 1
	mf2_capture mf2_capture_i (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.cpu_addr  (cpu_addr),
		.cpu_dout  (cpu_dout),
		.io_wr     (io_wr),
		.mem_wr    (mem_wr),
		.ram_en    (ram_en),
		.ram_addr  (ram_addr),
		.ram_wdata (ram_wdata),
		.ram_we    (ram_we)
	);

	// Stage 2
	mf2_ram mf2_ram_i (
		.clk_sys   (clk_sys),
		.ram_addr  (ram_addr),
		.ram_wdata (ram_wdata),
		.ram_we    (ram_we),
		.mem_rd    (mem_rd),
		.ram_en    (ram_en),
		.mf2_dout  (mf2_dout)
	);

endmodule

`default_nettype wire

// File: verif/tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

// Free-running system clock for the testbench
module tb_clock (
	output logic clk_sys
);

	localparam realtime HALF_PERIOD = 10ns;   // 20 ns period

	initial begin
		clk_sys = 1'b0;
	end

	always #(HALF_PERIOD) clk_sys = ~clk_sys;

endmodule

`default_nettype wire

// File: verif/tb_mf2_unit.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mf2_unit
	import mf2_pkg::*;
();

	// Reset 16, RAM test about 16 x 7, the rest a few hundred cycles
	localparam int WATCHDOG_CYCLES = 2000;

	logic      clk_sys;
	logic      reset;
	mf2_mode_t mode;
	cpu_addr_t cpu_addr;
	cpu_data_t cpu_dout;
	logic      m1;
	logic      io_wr;
	logic      mem_rd;
	logic      mem_wr;
	logic      key_nmi;
	wire       nmi;
	wire       mf2_en;
	wire       rom_en;
	wire       ram_en;
	cpu_data_t mf2_dout;

	int          check_count;
	int          error_count;
	logic [31:0] lcg_state;
	cpu_data_t   ref_mem [8192];   // Expected RAM contents

	tb_clock tb_clock_i (
		.clk_sys (clk_sys)
	);

	mf2_unit mf2_unit_i (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.mode     (mode),
		.cpu_addr (cpu_addr),
		.cpu_dout (cpu_dout),
		.m1       (m1),
		.io_wr    (io_wr),
		.mem_rd   (mem_rd),
		.mem_wr   (mem_wr),
		.key_nmi  (key_nmi),
		.nmi      (nmi),
		.mf2_en   (mf2_en),
		.rom_en   (rom_en),
		.ram_en   (ram_en),
		.mf2_dout (mf2_dout)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	//////////////////////////////
	// Compare tasks
	//////////////////////////////

	task automatic check_bit(input string name, input logic expected, input logic actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("MISMATCH %s: expected %b, actual %b", name, expected, actual);
		end
	endtask

	task automatic check_data(input string name, input cpu_data_t expected,
		input cpu_data_t actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	//////////////////////////////
	// Bus cycles
	//////////////////////////////

	task automatic apply_reset(input mf2_mode_t reset_mode);
		@(negedge clk_sys);
		reset = 1'b1;
		mode  = reset_mode;
		repeat (16) @(negedge clk_sys);
		reset = 1'b0;
	endtask

	task automatic io_write(input cpu_addr_t addr, input cpu_data_t data);
		@(negedge clk_sys);
		cpu_addr = addr;
		cpu_dout = data;
		io_wr    = 1'b1;
		@(negedge clk_sys);
		io_wr = 1'b0;
		@(negedge clk_sys);   // Cell written by now
	endtask

	task automatic mem_write(input cpu_addr_t addr, input cpu_data_t data);
		@(negedge clk_sys);
		cpu_addr = addr;
		cpu_dout = data;
		mem_wr   = 1'b1;
		@(negedge clk_sys);
		mem_wr = 1'b0;
		@(negedge clk_sys);
	endtask

	// Address and mem_rd held three cycles, then sampled
	task automatic mem_read(input cpu_addr_t addr, output cpu_data_t data);
		@(negedge clk_sys);
		cpu_addr = addr;
		mem_rd   = 1'b1;
		repeat (3) @(negedge clk_sys);
		data   = mf2_dout;
		mem_rd = 1'b0;
	endtask

	// Same timing as a read but mem_rd stays low
	task automatic idle_read(input cpu_addr_t addr, output cpu_data_t data);
		@(negedge clk_sys);
		cpu_addr = addr;
		repeat (3) @(negedge clk_sys);
		data = mf2_dout;
	endtask

	task automatic fetch(input cpu_addr_t addr);
		@(negedge clk_sys);
		cpu_addr = addr;
		m1       = 1'b1;
		@(negedge clk_sys);
		m1 = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic set_addr(input cpu_addr_t addr);
		@(negedge clk_sys);
		cpu_addr = addr;
		@(negedge clk_sys);
	endtask

	task automatic pulse_key();
		@(negedge clk_sys);
		key_nmi = 1'b1;
		@(negedge clk_sys);
		key_nmi = 1'b0;
		@(negedge clk_sys);
	endtask

	//////////////////////////////
	// Directed tests
	//////////////////////////////

	task automatic test_reset_state();
		cpu_data_t data;
		check_bit("reset nmi", 1'b0, nmi);
		check_bit("reset mf2_en", 1'b0, mf2_en);
		check_bit("reset rom_en", 1'b0, rom_en);
		check_bit("reset ram_en", 1'b0, ram_en);
		mem_read(16'h2000, data);
		check_data("reset read", 8'hFF, data);   // Not paged in
	endtask

	task automatic test_freeze();
		pulse_key();
		check_bit("freeze nmi set", 1'b1, nmi);
		fetch(16'h0066);
		check_bit("freeze mf2_en", 1'b1, mf2_en);
		check_bit("freeze nmi clear", 1'b0, nmi);
		set_addr(16'h0100);
		check_bit("freeze rom_en", 1'b1, rom_en);
		check_bit("freeze ram_en low", 1'b0, ram_en);
		set_addr(16'h2100);
		check_bit("freeze ram_en", 1'b1, ram_en);
		check_bit("freeze rom_en low", 1'b0, rom_en);
	endtask

	task automatic test_ram();
		cpu_addr_t addrs [16];
		cpu_data_t data;
		for (int i = 0; i < 16; i++) begin
			lcg_state = lcg_next(lcg_state);
			addrs[i]  = {3'b001, lcg_state[28:16]};   // Inside 2000 to 3FFF
			lcg_state = lcg_next(lcg_state);
			data      = lcg_state[23:16];
			ref_mem[addrs[i][12:0]] = data;
			mem_write(addrs[i], data);
		end
		for (int i = 0; i < 16; i++) begin
			mem_read(addrs[i], data);
			check_data($sformatf("ram read %h", addrs[i]), ref_mem[addrs[i][12:0]], data);
		end
		idle_read(addrs[0], data);
		check_data("ram without mem_rd", 8'hFF, data);   // Paged in but not read
	endtask

	task automatic test_shadow();
		cpu_data_t data;
		io_write(16'h7F00, 8'h03);   // Pen index 3
		io_write(16'h7F00, 8'h45);
		mem_read(16'h3F93, data);
		check_data("shadow pen 3", 8'h45, data);
		io_write(16'hBC00, 8'h07);
		io_write(16'hBD00, 8'h1E);
		mem_read(16'h3DB7, data);
		check_data("shadow crtc r7", 8'h1E, data);
		io_write(16'h7F00, 8'h8D);
		mem_read(16'h3FEF, data);
		check_data("shadow mode", 8'h8D, data);
		io_write(16'hDF00, 8'h07);
		mem_read(16'h3AAC, data);
		check_data("shadow rom select", 8'h07, data);
		io_write(16'hF700, 8'h82);
		mem_read(16'h37FF, data);
		check_data("shadow ppi control", 8'h82, data);
	endtask

	task automatic test_paging();
		io_write(16'hFEEA, 8'h00);
		check_bit("page out", 1'b0, mf2_en);
		io_write(16'hFEE8, 8'h00);
		check_bit("page in", 1'b1, mf2_en);
		fetch(16'h0065);
		check_bit("hide keeps mf2_en", 1'b1, mf2_en);
		io_write(16'hFEEA, 8'h00);
		check_bit("hidden page out", 1'b0, mf2_en);
		io_write(16'hFEE8, 8'h00);
		check_bit("hidden page in ignored", 1'b0, mf2_en);
	endtask

	task automatic test_disabled();
		apply_reset(mf2_mode_disabled);
		check_bit("disabled after reset", 1'b0, mf2_en);
		pulse_key();
		check_bit("disabled nmi", 1'b0, nmi);
		fetch(16'h0066);
		check_bit("disabled mf2_en", 1'b0, mf2_en);
	endtask

	initial begin
		reset       = 1'b1;
		mode        = mf2_mode_enabled;
		cpu_addr    = '0;
		cpu_dout    = '0;
		m1          = 1'b0;
		io_wr       = 1'b0;
		mem_rd      = 1'b0;
		mem_wr      = 1'b0;
		key_nmi     = 1'b0;
		check_count = 0;
		error_count = 0;
		lcg_state   = 32'd43;

		apply_reset(mf2_mode_enabled);
		test_reset_state();
		test_freeze();
		test_ram();
		test_shadow();
		test_paging();
		test_disabled();

		$display("Checks run: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

	// Watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("Timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire
